/* ps2_pkg.sv */
package ps2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // start, eight data bits lsb first, odd parity, stop
    localparam int unsigned FRAME_BITS = 11;
    localparam int unsigned DATA_BITS  = 8;

    typedef logic [DATA_BITS-1:0] scan_code_t;

    // prefix byte the keyboard sends ahead of a released key
    localparam scan_code_t BREAK_CODE = 8'hF0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // status and display
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // both flags are sticky until reset
    typedef struct packed {
        logic frame_err;    // bad parity or bad stop bit seen
        logic overflow;     // good byte dropped on a full FIFO
    } rx_status_t;

    // what the tracker wants shown
    typedef struct packed {
        scan_code_t code;
        logic       blank;
    } key_view_t;

    // active low, bit 0 is segment a up to bit 6 for g, bit 7 the dp
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } seg_pair_t;

    // all segments and the dp dark
    localparam logic [7:0] SEG_OFF = 8'hFF;

endpackage

/* ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx
#(
    parameter int unsigned FIFO_DEPTH  = 8,    // power of two
    parameter int unsigned SYNC_STAGES = 2     // two or more
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    input  logic                 pop,
    output logic                 ready,
    output ps2_pkg::scan_code_t  data,
    output ps2_pkg::rx_status_t  status
);

    import ps2_pkg::*;

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(FIFO_DEPTH);
    localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_last;
    logic                   fall;
    logic                   dat_q;

    logic [3:0]             bit_cnt;
    logic [FRAME_BITS-2:0]  shift;     // start in bit 0, parity on top
    logic                   frame_end;
    logic                   frame_ok;

    scan_code_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line synchronizer and falling edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;    // both lines idle high
            dat_sync <= '1;
            clk_last <= 1'b1;
            fall     <= 1'b0;
            dat_q    <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_dat};
            clk_last <= clk_sync[SYNC_STAGES-1];
            fall     <= clk_last & ~clk_sync[SYNC_STAGES-1];
            dat_q    <= dat_sync[SYNC_STAGES-1];    // sampled alongside the edge pulse
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame shifter and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= '0;
        else if (fall)
            bit_cnt <= (bit_cnt == LAST_BIT) ? 4'd0 : bit_cnt + 4'd1;
    end

    always_ff @(posedge clk)
    begin
        if (fall && bit_cnt != LAST_BIT)
            shift <= {dat_q, shift[FRAME_BITS-2:1]};
    end

    // the stop bit is still on dat_q when the last edge arrives
    assign frame_end = fall && (bit_cnt == LAST_BIT);
    assign frame_ok  = !shift[0] && (^shift[FRAME_BITS-2:1]) && dat_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte FIFO, first word falls through
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign full  = (count == DEPTH_C);
    assign wr_en = frame_end && frame_ok && !full;
    assign rd_en = pop && ready;
    assign ready = (count != '0);
    assign data  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= shift[DATA_BITS:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;    // wraps on the power of two depth
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            status <= '0;
        else
        begin
            if (frame_end && !frame_ok)
                status.frame_err <= 1'b1;
            if (frame_end && frame_ok && full)
                status.overflow <= 1'b1;    // byte is lost
        end
    end

    // the tracker must only pop a byte that is there
    pop_needs_data: assert property (@(posedge clk) disable iff (!rst) pop |-> count != '0);

    count_in_range: assert property (@(posedge clk) disable iff (!rst) count <= DEPTH_C);

endmodule

/* key_tracker.sv */
`timescale 1ns/1ps

module key_tracker
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ready,
    input  ps2_pkg::scan_code_t  data,
    output logic                 pop,
    output ps2_pkg::key_view_t   view
);

    import ps2_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        TAKE_MAKE,
        AWAIT_CODE
    } state_t;

    state_t state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // make and break tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a byte is taken on the edge that raises pop, and the view moves
    // on that same edge

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state      <= IDLE;
            pop        <= 1'b0;
            view.code  <= '0;
            view.blank <= 1'b1;
        end
        else
        begin
            pop <= 1'b0;    // never more than one cycle
            case (state)
                IDLE:
                begin
                    // ready still shows the old head while pop is high
                    if (ready && !pop)
                    begin
                        pop <= 1'b1;
                        if (data == BREAK_CODE)
                            state <= AWAIT_CODE;
                        else
                        begin
                            view.code  <= data;
                            view.blank <= 1'b0;
                            state      <= TAKE_MAKE;
                        end
                    end
                end

                TAKE_MAKE:
                begin
                    // the make code is shown, let the FIFO drop it
                    state <= IDLE;
                end

                AWAIT_CODE:
                begin
                    if (ready && !pop)
                    begin
                        pop        <= 1'b1;
                        view.blank <= 1'b1;    // code of the released key is not kept
                        state      <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    pop_single_cycle: assert property (@(posedge clk) disable iff (!rst) pop |=> !pop);

endmodule

/* seg7_hex.sv */
`timescale 1ns/1ps

module seg7_hex
(
    input  logic [3:0] nibble,
    input  logic       blank,
    output logic [7:0] seg
);

    import ps2_pkg::*;

    logic [7:0] glyph;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hex glyphs, active low, dp held off in bit 7
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (nibble)
            4'h0:    glyph = 8'hC0;
            4'h1:    glyph = 8'hF9;
            4'h2:    glyph = 8'hA4;
            4'h3:    glyph = 8'hB0;
            4'h4:    glyph = 8'h99;
            4'h5:    glyph = 8'h92;
            4'h6:    glyph = 8'h82;
            4'h7:    glyph = 8'hF8;
            4'h8:    glyph = 8'h80;
            4'h9:    glyph = 8'h90;
            4'hA:    glyph = 8'h88;
            4'hB:    glyph = 8'h83;    // lower case b
            4'hC:    glyph = 8'hC6;
            4'hD:    glyph = 8'hA1;    // lower case d
            4'hE:    glyph = 8'h86;
            default: glyph = 8'h8E;
        endcase
    end

    assign seg = blank ? SEG_OFF : glyph;

endmodule

/* ps2_key_display.sv */
`timescale 1ns/1ps

module ps2_key_display
#(
    parameter int unsigned FIFO_DEPTH  = 8,
    parameter int unsigned SYNC_STAGES = 2
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    output ps2_pkg::seg_pair_t   seg,
    output ps2_pkg::rx_status_t  status
);

    import ps2_pkg::*;

    logic       ready;
    logic       pop;
    scan_code_t data;
    key_view_t  view;
    logic [7:0] seg_lo;
    logic [7:0] seg_hi;

    ps2_rx #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) ps2_rx_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .pop     (pop),
        .ready   (ready),
        .data    (data),
        .status  (status)
    );

    key_tracker key_tracker_i (
        .clk   (clk),
        .rst   (rst),
        .ready (ready),
        .data  (data),
        .pop   (pop),
        .view  (view)
    );

    // one digit per nibble, both dark together
    seg7_hex seg7_lo_i (.nibble(view.code[3:0]), .blank(view.blank), .seg(seg_lo));
    seg7_hex seg7_hi_i (.nibble(view.code[7:4]), .blank(view.blank), .seg(seg_hi));

    assign seg = '{hi: seg_hi, lo: seg_lo};

endmodule

/* tb_ps2_tasks.svh */
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected display words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// builds an active low word from the letters of the lit segments
function automatic logic [7:0] glyph_from_segments(input string lit);
    logic [7:0] word;
    int         i;
    word = 8'hFF;
    for (i = 0; i < lit.len(); i++)
        word[int'(lit[i]) - 97] = 1'b0;    // letter a is bit 0
    return word;
endfunction

function automatic logic [7:0] hex_glyph(input logic [3:0] nibble);
    case (nibble)
        4'h0:    return glyph_from_segments("abcdef");
        4'h1:    return glyph_from_segments("bc");
        4'h2:    return glyph_from_segments("abdeg");
        4'h3:    return glyph_from_segments("abcdg");
        4'h4:    return glyph_from_segments("bcfg");
        4'h5:    return glyph_from_segments("acdfg");
        4'h6:    return glyph_from_segments("acdefg");
        4'h7:    return glyph_from_segments("abc");
        4'h8:    return glyph_from_segments("abcdefg");
        4'h9:    return glyph_from_segments("abcdfg");
        4'hA:    return glyph_from_segments("abcefg");
        4'hB:    return glyph_from_segments("cdefg");    // lower case b
        4'hC:    return glyph_from_segments("adef");
        4'hD:    return glyph_from_segments("bcdeg");    // lower case d
        4'hE:    return glyph_from_segments("adefg");
        default: return glyph_from_segments("aefg");
    endcase
endfunction

function automatic seg_pair_t expected_seg(input logic blank, input scan_code_t code);
    seg_pair_t pair;
    pair.lo = blank ? 8'hFF : hex_glyph(code[3:0]);
    pair.hi = blank ? 8'hFF : hex_glyph(code[7:4]);
    return pair;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard side of the PS/2 lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// called on a falling system clock edge, returns on one
task automatic send_frame(input scan_code_t value, input logic bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};    // stop, parity, data, start
    for (i = 0; i < 11; i++)
    begin
        ps2_dat = frame[i];    // half a bit ahead of the falling edge
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b1;
    end
    ps2_dat = 1'b1;
    repeat (BIT_CLOCKS) @(negedge clk);    // idle gap before the next frame
endtask

`endif

/* tb_ps2_key_display.sv */
`timescale 1ns/1ps

module tb_ps2_key_display;

    import ps2_pkg::*;

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned RESET_CYCLES    = 5;
    localparam int unsigned BIT_CLOCKS      = 40;    // one PS/2 bit in system clocks
    localparam int unsigned HALF_BIT        = BIT_CLOCKS / 2;
    localparam int unsigned FRAME_CLOCKS    = FRAME_BITS * BIT_CLOCKS;
    localparam int unsigned CHECK_CLOCKS    = 60 * BIT_CLOCKS;
    localparam int unsigned FRAMES_PER_LINE = 30;
    localparam int unsigned MARGIN_CLOCKS   = 200;

    // one line of the vector file
    typedef struct packed {
        logic [7:0] op;
        scan_code_t code;
        logic       blank;
        scan_code_t exp_code;
        logic       frame_err;
    } vector_t;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    seg_pair_t  seg;
    rx_status_t status;

    vector_t    vectors[$];
    bit         vectors_loaded;
    int         errors;
    int         checks;

    `include "tb_ps2_tasks.svh"

    ps2_key_display #(
        .FIFO_DEPTH  (8),
        .SYNC_STAGES (2)
    ) ps2_key_display_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg     (seg),
        .status  (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector reading and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_vectors();
        int      fd;
        int      fields;
        string   line;
        string   op;
        int      code;
        int      blank;
        int      exp_code;
        int      frame_err;
        vector_t v;
        fd = $fopen("ps2_key_display_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the vector file ps2_key_display_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() == 0 || line.substr(0, 0) == "#")
                continue;    // column notes at the top
            fields = $sscanf(line, "%s %h %h %h %h", op, code, blank, exp_code, frame_err);
            if (fields <= 0)
                continue;
            if (fields != 5)
            begin
                $display("malformed line in the vector file: %s", line);
                errors++;
                continue;
            end
            v.op        = op[0];
            v.code      = code[7:0];
            v.blank     = blank[0];
            v.exp_code  = exp_code[7:0];
            v.frame_err = frame_err[0];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic check_outputs(input logic blank, input scan_code_t code, input logic frame_err);
        seg_pair_t exp_seg;
        exp_seg = expected_seg(blank, code);
        checks++;
        assert (seg.lo === exp_seg.lo)
        else
        begin
            errors++;
            $display("FAIL time %0t: seg.lo = %h, expected %h", $time, seg.lo, exp_seg.lo);
        end
        assert (seg.hi === exp_seg.hi)
        else
        begin
            errors++;
            $display("FAIL time %0t: seg.hi = %h, expected %h", $time, seg.hi, exp_seg.hi);
        end
        assert (status.frame_err === frame_err)
        else
        begin
            errors++;
            $display("FAIL time %0t: status.frame_err = %b, expected %b",
                     $time, status.frame_err, frame_err);
        end
        // overflow cannot be reached from the lines, so it has to stay clear
        assert (status.overflow === 1'b0)
        else
        begin
            errors++;
            $display("FAIL time %0t: status.overflow = %b, expected 0", $time, status.overflow);
        end
    endtask

    task automatic run_operation(input vector_t v);
        time start;
        start = $time;
        case (v.op)
            "P": send_frame(v.code, 1'b0);
            "R":
            begin
                send_frame(BREAK_CODE, 1'b0);
                send_frame(v.code, 1'b0);
            end
            "B": send_frame(v.code, 1'b1);
            default:
            begin
                $display("unknown operation %s in the vector file", v.op);
                errors++;
            end
        endcase
        while ($time - start < CHECK_CLOCKS * CLK_PERIOD)
            @(negedge clk);
        check_outputs(v.blank, v.exp_code, v.frame_err);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        rst     = 1'b0;
        ps2_clk = 1'b1;    // idle lines
        ps2_dat = 1'b1;
        errors  = 0;
        checks  = 0;
        load_vectors();
        if (vectors.size() == 0)
        begin
            $display("no operations were read from the vector file");
            errors++;
        end
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_outputs(1'b1, 8'h00, 1'b0);    // dark digits and clear status
        foreach (vectors[i])
            run_operation(vectors[i]);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        longint limit_clocks;
        wait (vectors_loaded);
        limit_clocks = longint'(vectors.size()) * FRAMES_PER_LINE * FRAME_CLOCKS
                       + RESET_CYCLES + MARGIN_CLOCKS;
        repeat (limit_clocks) @(posedge clk);
        $display("watchdog: the run did not finish within %0d clock cycles", limit_clocks);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* ps2_key_display_vectors.txt */
# op code blank exp_code frame_err, all values in hex
# op P press, R release (F0 then code), B frame with wrong parity
P 1C 0 1C 0
R 1C 1 1C 0
P 32 0 32 0
B 55 0 32 1
P 01 0 01 1
P 23 0 23 1
R 23 1 23 1
P 45 0 45 1
P 67 0 67 1
R 67 1 67 1
P 89 0 89 1
P AB 0 AB 1
B 3C 0 AB 1
P CD 0 CD 1
R CD 1 CD 1
B 11 1 CD 1
P EF 0 EF 1
P 10 0 10 1
P BA 0 BA 1
P DC 0 DC 1
P FE 0 FE 1
R FE 1 FE 1
P 98 0 98 1
R 12 1 98 1
P 76 0 76 1
P 54 0 54 1
R 54 1 54 1

/* sim.f */
+incdir+.
ps2_pkg.sv
ps2_rx.sv
key_tracker.sv
seg7_hex.sv
ps2_key_display.sv
tb_ps2_key_display.sv

/* Bender.yml */
package:
  name: ps2_key_display

sources:
  - files:
      - ps2_pkg.sv
      - ps2_rx.sv
      - key_tracker.sv
      - seg7_hex.sv
      - ps2_key_display.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ps2_key_display.sv
